// ==== source/soc_pkg.sv ====
// --------------------
// Shared bus types, address map, CSR register numbers and fixed words
// --------------------
`default_nettype none

package soc_pkg;

	// --------------------
	// Bus word types
	// --------------------
	// Byte address on the Wishbone side
	typedef logic [31:0] adr_t;
	// Data word, same width on Wishbone and CSR
	typedef logic [31:0] data_t;
	// One select bit per byte lane
	typedef logic [3:0] sel_t;
	// CSR word address, bank in 13:10 and register in 9:0
	typedef logic [13:0] csr_adr_t;

	// Decoded target of one bus cycle
	typedef enum logic [1:0] {
		REGION_BRAM,
		REGION_CSR,
		REGION_ABSENT
	} region_e;

	// Wishbone to CSR bridge sequence
	typedef enum logic [1:0] {
		IDLE,
		ADDRESS,
		ACK
	} bridge_state_e;

	// --------------------
	// Address map
	// --------------------
	// Values of address bits 31:29
	localparam logic [2:0] BRAM_REGION = 3'd1;
	localparam logic [2:0] CSR_REGION = 3'd4;

	// System controller bank and its registers
	localparam logic [3:0] SYSCTL_BANK = 4'd1;
	localparam logic [9:0] REG_SYSTEM_ID = 10'd0;
	localparam logic [9:0] REG_GPIO_IN = 10'd1;
	localparam logic [9:0] REG_GPIO_OUT = 10'd2;

	// "X401" in ASCII
	localparam logic [31:0] SYSTEM_ID = 32'h58343031;
	// Filler word of unmapped space
	localparam logic [31:0] ABSENT_DATA = 32'habadface;

endpackage

`default_nettype wire

// ==== source/soc_ifs.sv ====
// --------------------
// Wishbone link and CSR bus interfaces
// --------------------
`timescale 1ns/1ps
`default_nettype none

// --------------------
// Wishbone classic link
// --------------------
interface wb_if;
	// Request side
	logic cyc;
	logic stb;
	logic we;
	soc_pkg::adr_t adr;
	soc_pkg::sel_t sel;
	soc_pkg::data_t dat_w;
	// Response side
	soc_pkg::data_t dat_r;
	logic ack;

	// Decoder end
	modport master (
		output cyc, stb, we, adr, sel, dat_w,
		input dat_r, ack
	);

	// Target end
	modport slave (
		input cyc, stb, we, adr, sel, dat_w,
		output dat_r, ack
	);
endinterface

// --------------------
// CSR bus
// --------------------
interface csr_if;
	soc_pkg::csr_adr_t a;
	logic we;
	soc_pkg::data_t dw;
	// Zero when no register of the bank is addressed
	soc_pkg::data_t dr;

	modport bridge (
		output a, we, dw,
		input dr
	);

	modport periph (
		input a, we, dw,
		output dr
	);
endinterface

`default_nettype wire

// ==== source/wb_decode.sv ====
// --------------------
// Address decoder, strobe routing and response merge
// --------------------
`timescale 1ns/1ps
`default_nettype none

module wb_decode (
	// Host side Wishbone port
	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire wb_we_i,
	input wire soc_pkg::adr_t wb_adr_i,
	input wire soc_pkg::sel_t wb_sel_i,
	input wire soc_pkg::data_t wb_dat_i,
	output soc_pkg::data_t wb_dat_o,
	output logic wb_ack_o,
	// Target links
	wb_if.master bram_o,
	wb_if.master csr_o
);

	soc_pkg::region_e region;

	// --------------------
	// Decode
	// --------------------
	// Top three address bits pick the target
	always_comb begin
		case (wb_adr_i[31:29])
			soc_pkg::BRAM_REGION: region = soc_pkg::REGION_BRAM;
			soc_pkg::CSR_REGION: region = soc_pkg::REGION_CSR;
			default: region = soc_pkg::REGION_ABSENT;
		endcase
	end

	// --------------------
	// Request routing
	// --------------------
	always_comb begin
		// Only the selected target sees the cycle
		bram_o.cyc = wb_cyc_i & (region == soc_pkg::REGION_BRAM);
		bram_o.stb = wb_stb_i & (region == soc_pkg::REGION_BRAM);
		csr_o.cyc = wb_cyc_i & (region == soc_pkg::REGION_CSR);
		csr_o.stb = wb_stb_i & (region == soc_pkg::REGION_CSR);
		// Payload is shared, harmless without a strobe
		bram_o.we = wb_we_i;
		bram_o.adr = wb_adr_i;
		bram_o.sel = wb_sel_i;
		bram_o.dat_w = wb_dat_i;
		csr_o.we = wb_we_i;
		csr_o.adr = wb_adr_i;
		csr_o.sel = wb_sel_i;
		csr_o.dat_w = wb_dat_i;
	end

	// --------------------
	// Response merge
	// --------------------
	// Address is held by the master, so region stays valid until ack
	always_comb begin
		case (region)
			soc_pkg::REGION_BRAM: begin
				wb_dat_o = bram_o.dat_r;
				wb_ack_o = bram_o.ack;
			end
			soc_pkg::REGION_CSR: begin
				wb_dat_o = csr_o.dat_r;
				wb_ack_o = csr_o.ack;
			end
			default: begin
				// Absent device acks at once, writes go nowhere
				wb_dat_o = soc_pkg::ABSENT_DATA;
				wb_ack_o = wb_cyc_i & wb_stb_i;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/bram_slave.sv ====
// --------------------
// Wishbone block RAM with byte lane writes
// --------------------
`timescale 1ns/1ps
`default_nettype none

module bram_slave #(
	parameter int BRAM_ADR_WIDTH = 10
) (
	input wire sys_clk,
	input wire rst1,
	wb_if.slave bus_i
);

	soc_pkg::data_t mem [0:(1 << BRAM_ADR_WIDTH) - 1];

	logic [BRAM_ADR_WIDTH-1:0] word_idx;
	logic access;

	// Word index, upper address bits alias
	assign word_idx = bus_i.adr[BRAM_ADR_WIDTH+1:2];

	// New request only while no ack is out
	assign access = bus_i.cyc & bus_i.stb & ~bus_i.ack;

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (access) begin
			// Byte lanes written one by one
			for (int i = 0; i < 4; i++) begin
				if (bus_i.we && bus_i.sel[i]) begin
					mem[word_idx][8*i +: 8] <= bus_i.dat_w[8*i +: 8];
				end
			end
			// Read word lines up with ack
			bus_i.dat_r <= mem[word_idx];
		end
	end

	// --------------------
	// Acknowledge
	// --------------------
	// Single cycle pulse, cleared even if stb is still high
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			bus_i.ack <= 1'b0;
		end else begin
			bus_i.ack <= access;
		end
	end

endmodule

`default_nettype wire

// ==== source/csr_bridge.sv ====
// --------------------
// Wishbone to CSR bridge FSM
// --------------------
`timescale 1ns/1ps
`default_nettype none

module csr_bridge (
	input wire sys_clk,
	input wire rst1,
	wb_if.slave bus_i,
	csr_if.bridge csr_o
);

	soc_pkg::bridge_state_e state;

	// --------------------
	// Sequencer
	// --------------------
	// IDLE latches the request, ADDRESS lets the bank register dr,
	// ACK hands the result back
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			state <= soc_pkg::IDLE;
			csr_o.we <= 1'b0;
		end else begin
			case (state)
				soc_pkg::IDLE: begin
					if (bus_i.cyc && bus_i.stb) begin
						// Write strobe for one cycle only
						csr_o.we <= bus_i.we;
						state <= soc_pkg::ADDRESS;
					end
				end
				soc_pkg::ADDRESS: begin
					csr_o.we <= 1'b0;
					state <= soc_pkg::ACK;
				end
				default: begin
					// Master drops stb on this edge
					state <= soc_pkg::IDLE;
				end
			endcase
		end
	end

	// --------------------
	// Address and write data
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (state == soc_pkg::IDLE && bus_i.cyc && bus_i.stb) begin
			// Word address, byte lanes dropped
			csr_o.a <= bus_i.adr[15:2];
			csr_o.dw <= bus_i.dat_w;
		end
	end

	// --------------------
	// Response
	// --------------------
	// dr is fresh during ACK, the bank registered it one cycle after a
	assign bus_i.ack = (state == soc_pkg::ACK);
	assign bus_i.dat_r = bus_i.ack ? csr_o.dr : '0;

endmodule

`default_nettype wire

// ==== source/sysctl_regs.sv ====
// --------------------
// System controller CSR bank, GPIO and system ID
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sysctl_regs #(
	parameter int N_GPIO_IN = 13,
	parameter int N_GPIO_OUT = 14
) (
	input wire sys_clk,
	input wire rst1,
	csr_if.periph csr_i,
	input wire [N_GPIO_IN-1:0] gpio_in_i,
	output logic [N_GPIO_OUT-1:0] gpio_out_o
);

	logic [N_GPIO_IN-1:0] gpio_in_meta;
	logic [N_GPIO_IN-1:0] gpio_in_sync;
	logic bank_hit;
	logic [9:0] reg_idx;

	// Two stage input synchronizer
	always_ff @(posedge sys_clk) begin
		gpio_in_meta <= gpio_in_i;
		gpio_in_sync <= gpio_in_meta;
	end

	assign bank_hit = (csr_i.a[13:10] == soc_pkg::SYSCTL_BANK);
	assign reg_idx = csr_i.a[9:0];

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			csr_i.dr <= '0;
			gpio_out_o <= '0;
		end else begin
			// Idle value zero, lets banks be ORed together
			csr_i.dr <= '0;
			if (bank_hit) begin
				case (reg_idx)
					soc_pkg::REG_SYSTEM_ID: csr_i.dr <= soc_pkg::SYSTEM_ID;
					soc_pkg::REG_GPIO_IN: csr_i.dr <= soc_pkg::data_t'(gpio_in_sync);
					soc_pkg::REG_GPIO_OUT: csr_i.dr <= soc_pkg::data_t'(gpio_out_o);
					default: csr_i.dr <= '0;
				endcase
				// Only the low bits of the output register exist
				if (csr_i.we && reg_idx == soc_pkg::REG_GPIO_OUT) begin
					gpio_out_o <= csr_i.dw[N_GPIO_OUT-1:0];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/soc_core.sv ====
// --------------------
// SoC bus backbone top, decoder with RAM, CSR bridge and sysctl
// --------------------
`timescale 1ns/1ps
`default_nettype none

module soc_core #(
	parameter int BRAM_ADR_WIDTH = 10,
	parameter int N_GPIO_IN = 13,
	parameter int N_GPIO_OUT = 14
) (
	input wire sys_clk,
	input wire rst1,
	// Data bus slave port
	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire wb_we_i,
	input wire soc_pkg::adr_t wb_adr_i,
	input wire soc_pkg::sel_t wb_sel_i,
	input wire soc_pkg::data_t wb_dat_i,
	output soc_pkg::data_t wb_dat_o,
	output logic wb_ack_o,
	// General purpose I/O
	input wire [N_GPIO_IN-1:0] gpio_in_i,
	output logic [N_GPIO_OUT-1:0] gpio_out_o
);

	// Host link plus one link per target
	wb_if host_bus ();
	wb_if bram_bus ();
	wb_if csr_wb ();
	csr_if csr_bus ();

	// --------------------
	// Host link
	// --------------------
	assign host_bus.cyc = wb_cyc_i;
	assign host_bus.stb = wb_stb_i;
	assign host_bus.we = wb_we_i;
	assign host_bus.adr = wb_adr_i;
	assign host_bus.sel = wb_sel_i;
	assign host_bus.dat_w = wb_dat_i;
	assign wb_dat_o = host_bus.dat_r;
	assign wb_ack_o = host_bus.ack;

	// --------------------
	// Decoder
	// --------------------
	wb_decode u_decode (
		.wb_cyc_i(host_bus.cyc),
		.wb_stb_i(host_bus.stb),
		.wb_we_i(host_bus.we),
		.wb_adr_i(host_bus.adr),
		.wb_sel_i(host_bus.sel),
		.wb_dat_i(host_bus.dat_w),
		.wb_dat_o(host_bus.dat_r),
		.wb_ack_o(host_bus.ack),
		.bram_o(bram_bus.master),
		.csr_o(csr_wb.master)
	);

	// --------------------
	// Targets
	// --------------------
	// RAM at 0x20000000
	bram_slave #(.BRAM_ADR_WIDTH(BRAM_ADR_WIDTH)) u_bram (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.bus_i(bram_bus.slave)
	);

	// CSR space at 0x80000000
	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.bus_i(csr_wb.slave),
		.csr_o(csr_bus.bridge)
	);

	// Bank 1 of CSR space
	sysctl_regs #(.N_GPIO_IN(N_GPIO_IN), .N_GPIO_OUT(N_GPIO_OUT)) u_sysctl (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.csr_i(csr_bus.periph),
		.gpio_in_i(gpio_in_i),
		.gpio_out_o(gpio_out_o)
	);

endmodule

`default_nettype wire

// ==== sim/tb_soc_core.sv ====
// --------------------
// Testbench for soc_core with random RAM, CSR, GPIO and absent region traffic
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_soc_core;

	localparam int RAM_WORDS = 1024;
	localparam int N_IN = 13;
	localparam int N_OUT = 14;
	localparam int ACK_TIMEOUT = 20;
	// Bank 1 registers with the word address in bits 15:2
	localparam logic [31:0] ID_ADR = 32'h8000_1000;
	localparam logic [31:0] GPIO_IN_ADR = 32'h8000_1004;
	localparam logic [31:0] GPIO_OUT_ADR = 32'h8000_1008;
	// Same register in bank 2 where nothing lives
	localparam logic [31:0] OTHER_BANK_ADR = 32'h8000_2008;

	logic sys_clk;
	logic rst1;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [31:0] wb_adr_i;
	logic [3:0] wb_sel_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic wb_ack_o;
	logic [N_IN-1:0] gpio_in_i;
	logic [N_OUT-1:0] gpio_out_o;

	// Reference models
	logic [31:0] ram_model [0:RAM_WORDS-1];
	logic [N_OUT-1:0] gpio_model;

	integer seed;
	int checks;
	int errors;
	int timeouts;
	int lat;
	logic [31:0] rd_data;

	soc_core dut (
		.sys_clk(sys_clk),
		.rst1(rst1),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_sel_i(wb_sel_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.gpio_in_i(gpio_in_i),
		.gpio_out_o(gpio_out_o)
	);

	// 100 ns period
	always #50 sys_clk = ~sys_clk;

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// --------------------
	// Bus access
	// --------------------
	// Starts on a falling edge and returns on one with the bus idle
	task automatic bus_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat, input logic pulse_check);
		int waited;
		logic got_ack;
		waited = 0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wb_dat_i = dat;
		// Let a combinational ack settle
		#1;
		while (!wb_ack_o && waited < ACK_TIMEOUT) begin
			@(negedge sys_clk);
			waited++;
		end
		got_ack = wb_ack_o;
		lat = waited;
		rd_data = wb_dat_o;
		if (!got_ack) begin
			timeouts++;
			$display("Timeout: no ack within %0d cycles for address %h", ACK_TIMEOUT, adr);
		end
		// Strobe held one more cycle while a registered ack must already be gone
		@(negedge sys_clk);
		if (got_ack && pulse_check) begin
			compare("ack pulse width", 32'd0, 32'(wb_ack_o));
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		@(negedge sys_clk);
	endtask

	// Distinct word for every RAM index
	function automatic logic [31:0] fill_word(input logic [9:0] idx);
		return {6'd0, idx, 6'd0, idx} ^ 32'hc3c3_5a5a;
	endfunction

	task automatic ram_write(input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		bus_access(1'b1, adr, sel, dat, 1'b1);
		compare("ram write latency", 32'd1, lat);
		// Only the word index bits count
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				ram_model[adr[11:2]][8*b +: 8] = dat[8*b +: 8];
			end
		end
	endtask

	task automatic ram_read(input logic [31:0] adr);
		bus_access(1'b0, adr, 4'hf, 32'd0, 1'b1);
		compare("ram read latency", 32'd1, lat);
		compare("ram read data", ram_model[adr[11:2]], rd_data);
	endtask

	task automatic csr_read(input logic [31:0] adr, input string name,
		input logic [31:0] expected);
		bus_access(1'b0, adr, 4'hf, 32'd0, 1'b1);
		compare({name, " latency"}, 32'd2, lat);
		compare(name, expected, rd_data);
	endtask

	task automatic csr_write(input logic [31:0] adr, input logic [31:0] dat);
		bus_access(1'b1, adr, 4'hf, dat, 1'b1);
		compare("csr write latency", 32'd2, lat);
	endtask

	// Random address with bits 31:29 outside both mapped regions
	task automatic absent_adr(output logic [31:0] adr);
		logic [31:0] r;
		do begin
			r = $random(seed);
		end while (r[31:29] == 3'd1 || r[31:29] == 3'd4);
		adr = {r[31:2], 2'b00};
	endtask

	// --------------------
	// Stimulus
	// --------------------
	initial begin
		logic [31:0] r;
		logic [31:0] adr;
		logic [31:0] dat;
		seed = 32'h46878bab;
		checks = 0;
		errors = 0;
		timeouts = 0;
		sys_clk = 1'b0;
		rst1 = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = 32'd0;
		wb_sel_i = 4'd0;
		wb_dat_i = 32'd0;
		gpio_in_i = '0;
		gpio_model = '0;
		repeat (5) @(negedge sys_clk);
		rst1 = 1'b1;
		@(negedge sys_clk);

		// Reset state
		compare("reset ack", 32'd0, 32'(wb_ack_o));
		compare("reset gpio out", 32'd0, 32'(gpio_out_o));
		csr_read(GPIO_OUT_ADR, "gpio out after reset", 32'd0);

		// Known contents first in the RAM at 0x20000000
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_write({3'b001, 17'd0, i[9:0], 2'b00}, 4'hf, fill_word(i[9:0]));
		end

		// Random byte writes followed by aliased and random reads
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			adr = {3'b001, r[28:2], 2'b00};
			r = $random(seed);
			dat = $random(seed);
			ram_write(adr, r[3:0], dat);
			r = $random(seed);
			ram_read({3'b001, r[28:12], adr[11:2], 2'b00});
			r = $random(seed);
			ram_read({3'b001, r[28:2], 2'b00});
		end

		// System ID reads "X401"
		csr_read(ID_ADR, "system id", 32'h5834_3031);

		// Inputs held 3 cycles to pass the synchronizer
		for (int n = 0; n < 10; n++) begin
			r = $random(seed);
			gpio_in_i = r[N_IN-1:0];
			repeat (3) @(negedge sys_clk);
			csr_read(GPIO_IN_ADR, "gpio in", 32'(r[N_IN-1:0]));
		end

		// Output register keeps its low bits only
		for (int n = 0; n < 20; n++) begin
			dat = $random(seed);
			csr_write(GPIO_OUT_ADR, dat);
			gpio_model = dat[N_OUT-1:0];
			compare("gpio out pins", 32'(gpio_model), 32'(gpio_out_o));
			csr_read(GPIO_OUT_ADR, "gpio out readback", 32'(gpio_model));
			dat = $random(seed);
			csr_write(OTHER_BANK_ADR, dat);
			compare("gpio out after other bank", 32'(gpio_model), 32'(gpio_out_o));
		end
		csr_read(OTHER_BANK_ADR, "other bank read", 32'd0);

		// Absent region gives an immediate ack and the filler word
		for (int n = 0; n < 20; n++) begin
			absent_adr(adr);
			bus_access(1'b0, adr, 4'hf, 32'd0, 1'b0);
			compare("absent latency", 32'd0, lat);
			compare("absent read", 32'habad_face, rd_data);
			absent_adr(adr);
			// Low half aims at the GPIO output register and a RAM word
			adr[15:0] = GPIO_OUT_ADR[15:0];
			dat = $random(seed);
			bus_access(1'b1, adr, 4'hf, dat, 1'b0);
			compare("gpio out after absent write", 32'(gpio_model), 32'(gpio_out_o));
			ram_read({3'b001, 17'd0, adr[11:2], 2'b00});
		end

		$display("Checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
source/soc_pkg.sv
source/soc_ifs.sv
source/wb_decode.sv
source/bram_slave.sv
source/csr_bridge.sv
source/sysctl_regs.sv
source/soc_core.sv
sim/tb_soc_core.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the soc_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_soc_core \
	-f all.f -o tb_soc_core

./obj_dir/tb_soc_core > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
grep -q "TEST RESULT: PASS" sim.log
